// File: verilog/rv_pkg.sv
// Shared types and constants for the RV32I pipeline, imported by every RTL module
package rv_pkg;

    localparam int xlen       = 32;   // Data and address width
    localparam int reg_addr_w = 5;    // Register index width

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // Major opcodes kept by this core
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_pass_b = 4'd0,    // LUI
        alu_add    = 4'd1,
        alu_sub    = 4'd2,
        alu_sll    = 4'd3,
        alu_srl    = 4'd4,
        alu_sra    = 4'd5,
        alu_slt    = 4'd6,
        alu_sltu   = 4'd7,
        alu_and    = 4'd8,
        alu_or     = 4'd9,
        alu_xor    = 4'd10
    } alu_op_t;

    // Second ALU operand
    typedef enum logic [1:0] {
        sel_rs2   = 2'd0,
        sel_imm_i = 2'd1,
        sel_imm_s = 2'd2,
        sel_imm_u = 2'd3
    } operand_sel_t;

    // Matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    typedef struct packed {
        alu_op_t      alu_op;
        operand_sel_t operand_sel;
        logic         a_is_pc;      // AUIPC takes the PC as operand A
        logic         reg_write;
        logic         mem_read;
        logic         mem_write;
        mem_size_t    mem_size;
        logic         sign_ext;     // Signed loads
    } ctrl_t;

    typedef struct packed {
        ctrl_t        ctrl;
        word_t        pc;
        word_t        rs1_data;
        word_t        rs2_data;
        logic [11:0]  imm_i;        // Raw immediate fields, extended in execute
        logic [11:0]  imm_s;
        logic [19:0]  imm_u;
        reg_idx_t     rd;
    } id_ex_t;

    typedef struct packed {
        logic         reg_write;
        logic         mem_read;
        logic         mem_write;
        mem_size_t    mem_size;
        logic         sign_ext;
        word_t        alu_result;   // Also the data memory address
        word_t        store_data;
        reg_idx_t     rd;
    } ex_mem_t;

    // Register file write port and writeback trace
    typedef struct packed {
        logic         valid;
        reg_idx_t     rd;
        word_t        data;
    } rf_write_t;

endpackage

// File: verilog/fetch_stage.sv
// Fetch stage with PC, instruction memory written by the loader port, and the IF/ID register
`timescale 1ns/1ns

module fetch_stage
    import rv_pkg::*;
#(
    parameter int IMEM_BYTES = 512
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  imem_we,
    input  word_t imem_addr,
    input  word_t imem_wdata,
    output word_t if_instr,
    output word_t if_pc
);
    localparam int aw = $clog2(IMEM_BYTES);   // Byte address bits, size is a power of two

    logic [7:0]    imem [IMEM_BYTES];
    word_t         pc;
    word_t         fetch_word;
    logic [aw-1:0] rd_addr [4];
    logic [aw-1:0] ld_addr [4];

    // Byte addresses of the fetch and the load, wrapping at the memory size
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rd_addr[k] = pc[aw-1:0] + aw'(k);
            ld_addr[k] = imem_addr[aw-1:0] + aw'(k);
        end
    end

    assign fetch_word = {imem[rd_addr[3]], imem[rd_addr[2]],
                         imem[rd_addr[1]], imem[rd_addr[0]]};   // Little endian

    always_ff @(posedge clk) begin
        if (imem_we) begin
            for (int k = 0; k < 4; k++) begin
                imem[ld_addr[k]] <= imem_wdata[8*k +: 8];
            end
        end
    end

    // No branches, so the PC only steps
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc + word_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if_pc <= pc;
        if (reset) begin
            if_instr <= '0;            // Zero word decodes as a bubble
        end else begin
            if_instr <= fetch_word;
        end
    end

endmodule

// File: verilog/decode_stage.sv
// Decode stage that builds the control word and immediates and holds the ID/EX register
`timescale 1ns/1ns

module decode_stage
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  word_t    if_instr,
    input  word_t    if_pc,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output id_ex_t   id_ex
);
    opcode_t    opcode;
    logic [2:0] funct3;
    logic       alt;          // funct7 bit 5
    ctrl_t      ctrl;
    id_ex_t     id_ex_next;

    // ALU operation from funct3, used by register and immediate forms
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic sub,
                                         input logic sra);
        alu_op_t op;
        case (f3)
            3'b000:  op = sub ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = sra ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode  = opcode_t'(if_instr[6:0]);
    assign funct3  = if_instr[14:12];
    assign alt     = if_instr[30];
    assign rs1_idx = if_instr[19:15];
    assign rs2_idx = if_instr[24:20];

    always_comb begin
        ctrl = '0;                    // Unknown opcodes stay bubbles
        case (opcode)
            op_reg: begin
                ctrl.alu_op      = arith_op(funct3, alt, alt);
                ctrl.operand_sel = sel_rs2;
                ctrl.reg_write   = 1'b1;
            end
            op_imm: begin
                // Bit 30 is part of the immediate for ADDI
                ctrl.alu_op      = arith_op(funct3, 1'b0, alt);
                ctrl.operand_sel = sel_imm_i;
                ctrl.reg_write   = 1'b1;
            end
            op_load: begin
                ctrl.alu_op      = alu_add;
                ctrl.operand_sel = sel_imm_i;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_size    = mem_size_t'(funct3[1:0]);
                ctrl.sign_ext    = ~funct3[2];    // LBU and LHU set bit 2
            end
            op_store: begin
                ctrl.alu_op      = alu_add;
                ctrl.operand_sel = sel_imm_s;
                ctrl.mem_write   = 1'b1;
                ctrl.mem_size    = mem_size_t'(funct3[1:0]);
            end
            op_lui: begin
                ctrl.alu_op      = alu_pass_b;
                ctrl.operand_sel = sel_imm_u;
                ctrl.reg_write   = 1'b1;
            end
            op_auipc: begin
                ctrl.alu_op      = alu_add;
                ctrl.operand_sel = sel_imm_u;
                ctrl.a_is_pc     = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        id_ex_next.ctrl     = ctrl;
        id_ex_next.pc       = if_pc;
        id_ex_next.rs1_data = rs1_data;
        id_ex_next.rs2_data = rs2_data;
        id_ex_next.imm_i    = if_instr[31:20];
        id_ex_next.imm_s    = {if_instr[31:25], if_instr[11:7]};
        id_ex_next.imm_u    = if_instr[31:12];
        id_ex_next.rd       = if_instr[11:7];
    end

    always_ff @(posedge clk) begin
        id_ex <= id_ex_next;
        if (reset) begin
            id_ex.ctrl <= '0;
        end
    end

endmodule

// File: verilog/register_file.sv
// Integer register file with x0 tied to zero and write-through reads for the decode stage
`timescale 1ns/1ns

module register_file
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_idx_t  rs1_idx,
    input  reg_idx_t  rs2_idx,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  rf_write_t wr
);
    word_t regs [1:2**reg_addr_w-1];   // x0 has no storage

    // Same-cycle write wins over the stored value
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wr.valid && wr.rd == idx) begin
            return wr.data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_idx);
        rs2_data = read_port(rs2_idx);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (wr.valid && wr.rd != '0) begin
            regs[wr.rd] <= wr.data;
        end
    end

endmodule

// File: verilog/execute_stage.sv
// Execute stage with operand selection, ALU and the EX/MEM register
`timescale 1ns/1ns

module execute_stage
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  id_ex_t  id_ex,
    output ex_mem_t ex_mem
);
    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    word_t      alu_result;
    ex_mem_t    ex_mem_next;

    assign op_a = id_ex.ctrl.a_is_pc ? id_ex.pc : id_ex.rs1_data;   // PC for AUIPC

    // Immediates are sign-extended here, U-type goes to the upper bits
    always_comb begin
        case (id_ex.ctrl.operand_sel)
            sel_imm_i: op_b = {{(xlen-12){id_ex.imm_i[11]}}, id_ex.imm_i};
            sel_imm_s: op_b = {{(xlen-12){id_ex.imm_s[11]}}, id_ex.imm_s};
            sel_imm_u: op_b = {id_ex.imm_u, 12'b0};
            default:   op_b = id_ex.rs2_data;
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_pass_b: alu_result = op_b;
            alu_add:    alu_result = op_a + op_b;
            alu_sub:    alu_result = op_a - op_b;
            alu_sll:    alu_result = op_a << shamt;
            alu_srl:    alu_result = op_a >> shamt;
            alu_sra:    alu_result = $signed(op_a) >>> shamt;   // Fills with the sign bit
            alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_and:    alu_result = op_a & op_b;
            alu_or:     alu_result = op_a | op_b;
            alu_xor:    alu_result = op_a ^ op_b;
            default:    alu_result = '0;
        endcase
    end

    always_comb begin
        ex_mem_next.reg_write  = id_ex.ctrl.reg_write;
        ex_mem_next.mem_read   = id_ex.ctrl.mem_read;
        ex_mem_next.mem_write  = id_ex.ctrl.mem_write;
        ex_mem_next.mem_size   = id_ex.ctrl.mem_size;
        ex_mem_next.sign_ext   = id_ex.ctrl.sign_ext;
        ex_mem_next.alu_result = alu_result;
        ex_mem_next.store_data = id_ex.rs2_data;
        ex_mem_next.rd         = id_ex.rd;
    end

    always_ff @(posedge clk) begin
        ex_mem <= ex_mem_next;
        if (reset) begin
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
        end
    end

endmodule

// File: verilog/memory_stage.sv
// Memory stage with byte-addressed data memory, sized loads and stores, and the MEM/WB register
`timescale 1ns/1ns

module memory_stage
    import rv_pkg::*;
#(
    parameter int DMEM_BYTES = 512
) (
    input  logic      clk,
    input  logic      reset,
    input  ex_mem_t   ex_mem,
    output rf_write_t wb
);
    localparam int aw = $clog2(DMEM_BYTES);

    logic [7:0]    dmem [DMEM_BYTES];
    logic [aw-1:0] addr [4];
    word_t         raw_word;
    word_t         load_data;
    rf_write_t     wb_next;

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            addr[k] = ex_mem.alu_result[aw-1:0] + aw'(k);   // Wraps at the memory size
        end
    end

    // Store at the edge that ends the MEM cycle
    always_ff @(posedge clk) begin
        if (ex_mem.mem_write) begin
            case (ex_mem.mem_size)
                size_byte: dmem[addr[0]] <= ex_mem.store_data[7:0];
                size_half: begin
                    dmem[addr[0]] <= ex_mem.store_data[7:0];
                    dmem[addr[1]] <= ex_mem.store_data[15:8];
                end
                default: begin
                    for (int k = 0; k < 4; k++) begin
                        dmem[addr[k]] <= ex_mem.store_data[8*k +: 8];
                    end
                end
            endcase
        end
    end

    assign raw_word = {dmem[addr[3]], dmem[addr[2]], dmem[addr[1]], dmem[addr[0]]};

    always_comb begin
        case (ex_mem.mem_size)
            size_byte: load_data = {{24{ex_mem.sign_ext & raw_word[7]}}, raw_word[7:0]};
            size_half: load_data = {{16{ex_mem.sign_ext & raw_word[15]}}, raw_word[15:0]};
            default:   load_data = raw_word;
        endcase
    end

    always_comb begin
        wb_next.valid = ex_mem.reg_write && ex_mem.rd != '0;   // x0 writes are dropped
        wb_next.rd    = ex_mem.rd;
        wb_next.data  = ex_mem.mem_read ? load_data : ex_mem.alu_result;
    end

    always_ff @(posedge clk) begin
        wb <= wb_next;
        if (reset) begin
            wb.valid <= 1'b0;
        end
    end

endmodule

// File: verilog/riscv_pipeline.sv
// Top level of the five-stage RV32I pipeline with loader port and writeback trace
`timescale 1ns/1ns

module riscv_pipeline
    import rv_pkg::*;
#(
    parameter int IMEM_BYTES = 512,
    parameter int DMEM_BYTES = 512
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      imem_we,
    input  word_t     imem_addr,
    input  word_t     imem_wdata,
    output rf_write_t wb          // Also the register file write port
);
    word_t    if_instr;
    word_t    if_pc;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;

    fetch_stage #(
        .IMEM_BYTES (IMEM_BYTES)
    ) fetch_stage_i (
        .clk        (clk),
        .reset      (reset),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .if_instr   (if_instr),
        .if_pc      (if_pc)
    );

    decode_stage decode_stage_i (
        .clk      (clk),
        .reset    (reset),
        .if_instr (if_instr),
        .if_pc    (if_pc),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .id_ex    (id_ex)
    );

    register_file register_file_i (
        .clk      (clk),
        .reset    (reset),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr       (wb)
    );

    execute_stage execute_stage_i (
        .clk    (clk),
        .reset  (reset),
        .id_ex  (id_ex),
        .ex_mem (ex_mem)
    );

    memory_stage #(
        .DMEM_BYTES (DMEM_BYTES)
    ) memory_stage_i (
        .clk    (clk),
        .reset  (reset),
        .ex_mem (ex_mem),
        .wb     (wb)
    );

endmodule

// File: verification/riscv_pipeline_props.sv
// Concurrent checks on the writeback trace, bound into the pipeline top level for simulation
`timescale 1ns/1ns

module riscv_pipeline_props
    import rv_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input rf_write_t wb
);
    // MEM/WB register is cleared by reset
    valid_low_after_reset: assert property (
        @(posedge clk) reset |=> !wb.valid
    ) else $error("wb.valid was high in the cycle after reset");

    rd_nonzero: assert property (
        @(posedge clk) disable iff (reset) wb.valid |-> wb.rd != '0
    ) else $error("writeback to x0 was marked valid");

    no_unknown_data: assert property (
        @(posedge clk) disable iff (reset)
            !$isunknown(wb.valid) && (!wb.valid || !$isunknown(wb.data))
    ) else $error("writeback carried unknown bits");

endmodule

bind riscv_pipeline riscv_pipeline_props riscv_pipeline_props_i (
    .clk   (clk),
    .reset (reset),
    .wb    (wb)
);

// File: verification/riscv_pipeline_tb.sv
// Directed testbench for the RV32I pipeline; loads programs through the loader port, checks wb
`timescale 1ns/1ns

module riscv_pipeline_tb
    import rv_pkg::*;
();
    localparam int imem_words = 128;
    localparam int clk_period = 40;
    localparam int num_tests  = 5;
    localparam int run_margin = 8;                  // Pipeline depth plus slack
    // Each test loads the whole memory, then runs at most as long again
    localparam int watchdog_cycles = num_tests * (2 * imem_words + run_margin + 4) + 20;
    localparam word_t nop = 32'h0000_0013;          // ADDI x0, x0, 0

    logic      clk;
    logic      reset;
    logic      imem_we;
    word_t     imem_addr;
    word_t     imem_wdata;
    rf_write_t wb;

    int        seed;
    int        errors;
    int        checks;
    int        tests_run;
    word_t     prog [$];
    reg_idx_t  exp_rd [$];
    word_t     exp_data [$];

    riscv_pipeline #(
        .IMEM_BYTES (4 * imem_words),
        .DMEM_BYTES (512)
    ) riscv_pipeline_i (
        .clk        (clk),
        .reset      (reset),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .wb         (wb)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    function automatic word_t r_type(input logic [2:0] f3, input logic alt, input reg_idx_t rd,
                                     input reg_idx_t rs1, input reg_idx_t rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t i_type(input opcode_t opc, input logic [2:0] f3, input reg_idx_t rd,
                                     input reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [2:0] f3, input reg_idx_t rs1,
                                     input reg_idx_t rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic word_t u_type(input opcode_t opc, input reg_idx_t rd,
                                     input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // ISA result of the arithmetic forms, alt is instruction bit 30
    function automatic word_t arith_result(input logic [2:0] f3, input logic alt,
                                           input word_t a, input word_t b);
        word_t fill;
        fill = a[31] ? ~(32'hffff_ffff >> b[4:0]) : '0;     // Sign bits shifted in
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? (a >> b[4:0]) | fill : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %h, actual %h",
                     $time, name, expected, actual);
        end
    endtask

    // Two NOPs after each instruction cover the register hazard
    task automatic emit(input word_t instr);
        prog.push_back(instr);
        prog.push_back(nop);
        prog.push_back(nop);
    endtask

    task automatic expect_write(input reg_idx_t rd, input word_t data);
        if (rd != '0) begin                          // x0 writes leave no trace
            exp_rd.push_back(rd);
            exp_data.push_back(data);
        end
    endtask

    // LUI plus ADDI, upper part rounded for the signed low immediate
    task automatic set_reg(input reg_idx_t rd, input word_t value);
        word_t rounded;
        rounded = value + 32'h0000_0800;
        emit(u_type(op_lui, rd, rounded[31:12]));
        expect_write(rd, {rounded[31:12], 12'b0});
        emit(i_type(op_imm, 3'd0, rd, rd, value[11:0]));
        expect_write(rd, {rounded[31:12], 12'b0} + sext12(value[11:0]));
    endtask

    task automatic emit_load(input logic [2:0] f3, input reg_idx_t rd, input logic [11:0] off,
                             input word_t expected);
        emit(i_type(op_load, f3, rd, 5'd1, off));
        expect_write(rd, expected);
    endtask

    task automatic run_program(input string name);
        reg_idx_t got_rd [$];
        word_t    got_data [$];
        int       err_before;
        err_before = errors;
        if (prog.size() > imem_words - run_margin) begin
            errors++;
            $display("test %s: program does not fit in instruction memory", name);
        end
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < imem_words; i++) begin   // Zero fill clears older programs
            imem_we    = 1'b1;
            imem_addr  = word_t'(4 * i);
            imem_wdata = (i < prog.size()) ? prog[i] : '0;
            @(negedge clk);
        end
        imem_we = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        for (int c = 0; c < prog.size() + run_margin; c++) begin
            @(negedge clk);
            if (wb.valid === 1'b1) begin
                got_rd.push_back(wb.rd);
                got_data.push_back(wb.data);
            end
        end
        if (got_data.size() < exp_data.size()) begin
            errors++;
            $display("test %s: too few writebacks arrived, %0d of %0d",
                     name, got_data.size(), exp_data.size());
        end else if (got_data.size() > exp_data.size()) begin
            errors++;
            $display("test %s: more writebacks arrived than expected, %0d instead of %0d",
                     name, got_data.size(), exp_data.size());
        end
        for (int i = 0; i < exp_data.size() && i < got_data.size(); i++) begin
            check_value($sformatf("wb.rd[%0d]", i), word_t'(exp_rd[i]), word_t'(got_rd[i]));
            check_value($sformatf("wb.data[%0d]", i), exp_data[i], got_data[i]);
        end
        tests_run++;
        $display("test %s finished with %0d errors", name, errors - err_before);
        prog.delete();
        exp_rd.delete();
        exp_data.delete();
    endtask

    task automatic immediate_setup();
        for (int r = 1; r <= 6; r++) begin
            set_reg(reg_idx_t'(r), word_t'($random(seed)));
        end
        run_program("immediate setup");
    endtask

    task automatic register_arith();
        word_t      a;
        word_t      b;
        logic [2:0] f3;
        logic       alt;
        reg_idx_t   rd;
        a = $random(seed) | 32'h8000_0000;              // Negative, so SLT and SLTU differ
        b = ($random(seed) & 32'h7fff_ffe0) | 32'd7;    // Positive, shift by seven
        set_reg(5'd1, a);
        set_reg(5'd2, b);
        for (int k = 0; k < 10; k++) begin
            f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);   // SUB and SRA last
            alt = (k >= 8);
            rd  = reg_idx_t'(10 + k);
            emit(r_type(f3, alt, rd, 5'd1, 5'd2));
            expect_write(rd, arith_result(f3, alt, a, b));
        end
        run_program("register arithmetic");
    endtask

    task automatic immediate_ops();
        word_t       a;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        reg_idx_t    rd;
        a = $random(seed) | 32'h8000_0000;
        set_reg(5'd1, a);
        for (int k = 0; k < 9; k++) begin
            f3  = (k < 8) ? 3'(k) : 3'd5;
            alt = (k == 8);                              // SRAI
            rd  = reg_idx_t'(10 + k);
            imm = 12'($random(seed));
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = {1'b0, alt, 5'b0, imm[4:0] | 5'd1};   // Nonzero shift amount
            end
            emit(i_type(op_imm, f3, rd, 5'd1, imm));
            expect_write(rd, arith_result(f3, alt, a, sext12(imm)));
        end
        run_program("immediate operations");
    endtask

    task automatic store_load();
        word_t d;
        d = $random(seed) | 32'h8000_8080;              // Sign bit set in each tested lane
        set_reg(5'd1, 32'h0000_0100);
        set_reg(5'd2, d);
        emit(s_type(3'd2, 5'd1, 5'd2, 12'd0));          // SW x2, 0(x1)
        emit(s_type(3'd2, 5'd1, 5'd0, 12'd4));
        emit(s_type(3'd1, 5'd1, 5'd2, 12'd4));          // SH x2, 4(x1)
        emit(s_type(3'd2, 5'd1, 5'd0, 12'd8));
        emit(s_type(3'd0, 5'd1, 5'd2, 12'd9));          // SB x2, 9(x1)
        emit_load(3'd2, 5'd5, 12'd0, d);
        emit_load(3'd1, 5'd6, 12'd2, {{16{d[31]}}, d[31:16]});
        emit_load(3'd5, 5'd7, 12'd2, {16'b0, d[31:16]});
        emit_load(3'd0, 5'd8, 12'd3, {{24{d[31]}}, d[31:24]});
        emit_load(3'd4, 5'd9, 12'd1, {24'b0, d[15:8]});
        emit_load(3'd2, 5'd10, 12'd4, {16'b0, d[15:0]});
        emit_load(3'd1, 5'd11, 12'd4, {{16{d[15]}}, d[15:0]});
        emit_load(3'd2, 5'd12, 12'd8, {16'b0, d[7:0], 8'b0});
        emit_load(3'd0, 5'd13, 12'd9, {{24{d[7]}}, d[7:0]});
        run_program("store and load");
    endtask

    task automatic bubble_handling();
        word_t       pc;
        logic [19:0] imm;
        imm = 20'($random(seed));
        prog.push_back('0);
        prog.push_back('0);
        emit(i_type(op_imm, 3'd0, 5'd0, 5'd0, 12'h5a5));
        expect_write(5'd0, 32'h0000_05a5);
        emit(r_type(3'd0, 1'b0, 5'd0, 5'd0, 5'd0));
        pc = word_t'(4 * prog.size());
        emit(u_type(op_auipc, 5'd6, imm));
        expect_write(5'd6, pc + {imm, 12'b0});
        prog.push_back('0);
        emit(i_type(op_imm, 3'd0, 5'd7, 5'd0, 12'h123));
        expect_write(5'd7, 32'h0000_0123);
        run_program("bubbles");
    endtask

    initial begin
        seed       = 48;
        errors     = 0;
        checks     = 0;
        tests_run  = 0;
        reset      = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        repeat (2) @(negedge clk);
        immediate_setup();
        register_arith();
        immediate_ops();
        store_load();
        bubble_handling();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: riscv_pipeline.f
verilog/rv_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/register_file.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/riscv_pipeline.sv
verification/riscv_pipeline_props.sv
verification/riscv_pipeline_tb.sv

// File: Makefile
SRCS := $(shell cat riscv_pipeline.f)

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a source changes
obj_dir/Vriscv_pipeline_tb: riscv_pipeline.f $(SRCS)
	verilator --binary --timing --assert -f riscv_pipeline.f --top-module riscv_pipeline_tb

run: obj_dir/Vriscv_pipeline_tb
	obj_dir/Vriscv_pipeline_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir sim.log
